// ==== Makefile ====
SIM = obj_dir/tb_can_btl

.PHONY: all compile run clean

all: run

compile:
	verilator --binary --timing --assert -j 0 --top-module tb_can_btl -f vlog.f -o tb_can_btl

run: compile
	./$(SIM) > sim.log 2>&1 || true
	cat sim.log
	grep -q "RESULT: PASS" sim.log

clean:
	rm -rf obj_dir sim.log

// ==== can_bit_sequencer.sv ====
module can_bit_sequencer (
  input  logic                                clk,
  input  logic                                reset_b,
  input  logic                                init,
  input  logic                                tq_tick,
  input  logic [can_timing_pkg::timing_w-1:0] timing,
  input  logic                                rx_sync,
  input  logic                                rx_fall,
  input  logic                                busidle,
  input  logic                                interm3,
  input  logic                                txd,
  input  logic                                transmit,
  output logic                                sample,
  output logic                                clock,
  output logic                                rx_bit
);

  localparam int cnt_w  = can_timing_pkg::cnt_w;
  localparam int sjw_w  = can_timing_pkg::sjw_w;
  localparam int seg1_w = can_timing_pkg::seg1_w;
  localparam int seg2_w = can_timing_pkg::seg2_w;

  localparam logic [cnt_w-1:0] q_one = 1;

  can_timing_pkg::seg_state_t state;

  logic [cnt_w-1:0] q_cnt;        // quantum index within the current segment
  logic [cnt_w-1:0] len1;         // tseg1 length in quanta, may grow by resync
  logic [cnt_w-1:0] len2;         // tseg2 length in quanta, may shrink by resync
  logic             resync_done;  // one edge adjustment per bit
  logic             sample_q;
  logic             clock_q;

  logic [cnt_w-1:0] seg1_len;
  logic [cnt_w-1:0] seg2_len;
  logic [cnt_w-1:0] sjw_len;
  logic [cnt_w-1:0] elapsed;      // quanta since the end of sync
  logic [cnt_w-1:0] ext1;
  logic [cnt_w-1:0] cut2_len;
  logic [cnt_w-1:0] len2_eff;
  logic             hard_sync;
  logic             resync_ok;
  logic             resync1;
  logic             resync2;
  logic             end_seg2;

  // programmed lengths, register value plus one
  assign seg1_len = {{(cnt_w-seg1_w){1'b0}},
                     timing[can_timing_pkg::seg1_lsb +: seg1_w]} + q_one;
  assign seg2_len = {{(cnt_w-seg2_w){1'b0}},
                     timing[can_timing_pkg::seg2_lsb +: seg2_w]} + q_one;
  assign sjw_len  = {{(cnt_w-sjw_w){1'b0}},
                     timing[can_timing_pkg::sjw_lsb +: sjw_w]} + q_one;

  assign hard_sync = rx_fall & (busidle | interm3) & txd;
  assign resync_ok = rx_fall & txd & ~transmit & ~resync_done & ~hard_sync;
  assign resync1   = resync_ok && state == can_timing_pkg::seg_tseg1;
  assign resync2   = resync_ok && state == can_timing_pkg::seg_tseg2;

  // late edge, stretch tseg1 by the phase error up to sjw+1
  assign elapsed = q_cnt + q_one;
  assign ext1    = (elapsed < sjw_len) ? elapsed : sjw_len;

  // early edge, cut tseg2 so the bit ends no sooner than now
  assign cut2_len = (len2 >= q_cnt + sjw_len + q_one) ? len2 - sjw_len : q_cnt + q_one;
  assign len2_eff = resync2 ? cut2_len : len2;
  assign end_seg2 = state == can_timing_pkg::seg_tseg2 && q_cnt == len2_eff - q_one;

  always_ff @(posedge clk)
  begin
    if (!reset_b || init)
    begin
      state       <= can_timing_pkg::seg_sync;
      q_cnt       <= '0;
      len1        <= seg1_len;
      len2        <= seg2_len;
      resync_done <= 1'b0;
      sample_q    <= 1'b0;
      clock_q     <= 1'b0;
      rx_bit      <= 1'b1;  // recessive
    end
    else
    begin
      sample_q <= 1'b0;
      clock_q  <= 1'b0;
      if (tq_tick)
      begin
        if (hard_sync)
        begin
          // this quantum counts as sync, tseg1 starts next
          state       <= can_timing_pkg::seg_tseg1;
          q_cnt       <= '0;
          len1        <= seg1_len;
          len2        <= seg2_len;
          resync_done <= 1'b1;
          clock_q     <= 1'b1;
        end
        else
        begin
          case (state)
            can_timing_pkg::seg_sync:
            begin
              state <= can_timing_pkg::seg_tseg1;
              q_cnt <= '0;
            end
            can_timing_pkg::seg_tseg1:
            begin
              if (resync1)
              begin
                len1        <= len1 + ext1;
                q_cnt       <= q_cnt + q_one;
                resync_done <= 1'b1;
              end
              else if (q_cnt == len1 - q_one)
              begin
                state    <= can_timing_pkg::seg_tseg2;
                q_cnt    <= '0;
                sample_q <= 1'b1;
                rx_bit   <= rx_sync;  // sample point
              end
              else
                q_cnt <= q_cnt + q_one;
            end
            can_timing_pkg::seg_tseg2:
            begin
              len2 <= len2_eff;
              if (resync2)
                resync_done <= 1'b1;
              if (end_seg2)
              begin
                state       <= can_timing_pkg::seg_sync;
                q_cnt       <= '0;
                len1        <= seg1_len;  // new bit takes the current timing word
                len2        <= seg2_len;
                resync_done <= 1'b0;
                clock_q     <= 1'b1;
              end
              else
                q_cnt <= q_cnt + q_one;
            end
            default: state <= can_timing_pkg::seg_sync;
          endcase
        end
      end
    end
  end

  // a pulse already in flight is dropped when init is set
  assign sample = sample_q & ~init;
  assign clock  = clock_q & ~init;

endmodule

// ==== can_btl_properties.sv ====
module can_btl_properties (
  input logic clk,
  input logic reset_b,
  input logic init,
  input logic sample,
  input logic clock,
  input logic ack
);

  // bit start and sample point fall in different quanta
  sample_clock_apart: assert property (@(posedge clk) disable iff (!reset_b)
    !(sample && clock))
    else $error("sample and clock high in the same cycle");

  ack_single: assert property (@(posedge clk) disable iff (!reset_b)
    ack |=> !ack)
    else $error("ack held high for more than one cycle");

  // pulse flops are cleared by the edge that sees init
  quiet_in_init: assert property (@(posedge clk) disable iff (!reset_b)
    init |=> !(sample || clock))
    else $error("bit timing pulse while init is high");

endmodule

bind can_bit_sequencer can_btl_properties can_btl_properties_seq_i (
  .clk(clk),
  .reset_b(reset_b),
  .init(init),
  .sample(sample_q),
  .clock(clock_q),
  .ack(1'b0)  // no bus port here
);

bind can_btl_regs can_btl_properties can_btl_properties_regs_i (
  .clk(clk),
  .reset_b(reset_b),
  .init(init),
  .sample(1'b0),
  .clock(1'b0),
  .ack(ack)
);

// ==== can_btl_regs.sv ====
module can_btl_regs #(
  parameter int div_w = can_timing_pkg::div_w
) (
  input  logic                                clk,
  input  logic                                reset_b,
  input  logic                                cyc,
  input  logic                                stb,
  input  logic                                we,
  input  logic [can_reg_pkg::wb_adr_w-1:0]    adr,
  input  logic [can_reg_pkg::wb_dat_w-1:0]    dat_w,
  output logic                                ack,
  output logic [can_reg_pkg::wb_dat_w-1:0]    dat_r,
  output logic [div_w-1:0]                    div_factor,
  output logic [can_timing_pkg::timing_w-1:0] timing,
  output logic                                init,
  output logic                                tst_off
);

  localparam int timing_w = can_timing_pkg::timing_w;
  localparam int sjw_w    = can_timing_pkg::sjw_w;
  localparam int seg1_w   = can_timing_pkg::seg1_w;
  localparam int seg2_w   = can_timing_pkg::seg2_w;

  logic                             access;  // first cycle of a transfer
  logic [can_reg_pkg::wb_dat_w-1:0] rd_data;
  can_reg_pkg::reg_addr_t           addr;

  assign access = cyc & stb & ~ack;
  assign addr   = can_reg_pkg::reg_addr_t'(adr);

  // read mux, unused addresses read as zero
  always_comb
  begin
    rd_data = '0;
    case (addr)
      can_reg_pkg::addr_div:    rd_data[div_w-1:0] = div_factor;
      can_reg_pkg::addr_timing: rd_data[timing_w-1:0] = timing;
      can_reg_pkg::addr_ctrl:
      begin
        rd_data[can_reg_pkg::ctrl_rr_bit]      = init;
        rd_data[can_reg_pkg::ctrl_tst_off_bit] = tst_off;
      end
      default:                  rd_data = '0;
    endcase
  end

  // single cycle ack, never two in a row
  always_ff @(posedge clk)
  begin
    if (!reset_b)
      ack <= 1'b0;
    else
      ack <= access;
  end

  always_ff @(posedge clk)
  begin
    if (access)
      dat_r <= rd_data;  // valid while ack is high
  end

  always_ff @(posedge clk)
  begin
    if (!reset_b)
    begin
      div_factor <= div_w'(can_reg_pkg::div_rst);
      timing[can_timing_pkg::sjw_lsb +: sjw_w]   <= sjw_w'(can_reg_pkg::sjw_rst);
      timing[can_timing_pkg::seg1_lsb +: seg1_w] <= seg1_w'(can_reg_pkg::seg1_rst);
      timing[can_timing_pkg::seg2_lsb +: seg2_w] <= seg2_w'(can_reg_pkg::seg2_rst);
      init    <= can_reg_pkg::ctrl_rr_rst;
      tst_off <= can_reg_pkg::ctrl_tst_off_rst;
    end
    else if (access && we)
    begin
      case (addr)
        can_reg_pkg::addr_div:    div_factor <= dat_w[div_w-1:0];
        can_reg_pkg::addr_timing: timing <= dat_w[timing_w-1:0];
        can_reg_pkg::addr_ctrl:
        begin
          init    <= dat_w[can_reg_pkg::ctrl_rr_bit];
          tst_off <= dat_w[can_reg_pkg::ctrl_tst_off_bit];
        end
        default: ;  // write to a hole is acked and dropped
      endcase
    end
  end

endmodule

// ==== can_btl_top.sv ====
module can_btl_top #(
  parameter int div_w = can_timing_pkg::div_w
) (
  input  logic                             clk,
  input  logic                             reset_b,
  input  logic                             cyc,
  input  logic                             stb,
  input  logic                             we,
  input  logic [can_reg_pkg::wb_adr_w-1:0] adr,
  input  logic [can_reg_pkg::wb_dat_w-1:0] dat_w,
  input  logic                             rxd,
  input  logic                             txd,
  input  logic                             busidle,
  input  logic                             interm3,
  input  logic                             transmit,
  output logic                             ack,
  output logic [can_reg_pkg::wb_dat_w-1:0] dat_r,
  output logic                             sample,
  output logic                             clock,
  output logic                             rx_bit,
  output logic                             tst_clock,
  output logic                             tst_sample
);

  logic [div_w-1:0]                    div_factor;
  logic [can_timing_pkg::timing_w-1:0] timing;
  logic                                init;
  logic                                tst_off;
  logic                                tq_tick;
  logic                                rx_sync;
  logic                                rx_fall;

  can_btl_regs #(
    .div_w(div_w)
  ) can_btl_regs_i (
    .clk(clk),
    .reset_b(reset_b),
    .cyc(cyc),
    .stb(stb),
    .we(we),
    .adr(adr),
    .dat_w(dat_w),
    .ack(ack),
    .dat_r(dat_r),
    .div_factor(div_factor),
    .timing(timing),
    .init(init),
    .tst_off(tst_off)
  );

  can_tq_prescaler #(
    .div_w(div_w)
  ) can_tq_prescaler_i (
    .clk(clk),
    .reset_b(reset_b),
    .init(init),
    .div_factor(div_factor),
    .tq_tick(tq_tick)
  );

  can_rx_sync can_rx_sync_i (
    .clk(clk),
    .reset_b(reset_b),
    .init(init),
    .tq_tick(tq_tick),
    .rxd(rxd),
    .rx_sync(rx_sync),
    .rx_fall(rx_fall)
  );

  can_bit_sequencer can_bit_sequencer_i (
    .clk(clk),
    .reset_b(reset_b),
    .init(init),
    .tq_tick(tq_tick),
    .timing(timing),
    .rx_sync(rx_sync),
    .rx_fall(rx_fall),
    .busidle(busidle),
    .interm3(interm3),
    .txd(txd),
    .transmit(transmit),
    .sample(sample),
    .clock(clock),
    .rx_bit(rx_bit)
  );

  // test pins for the host, masked by tst_off
  assign tst_clock  = clock & ~tst_off;
  assign tst_sample = sample & ~tst_off;

endmodule

// ==== can_reg_pkg.sv ====
package can_reg_pkg;

  // wishbone classic slave sizes
  localparam int wb_adr_w = 2;
  localparam int wb_dat_w = 16;

  // register map, word addressed
  typedef enum logic [wb_adr_w-1:0] {
    addr_div    = 2'd0,  // prescaler divider
    addr_timing = 2'd1,  // {sjw, seg1, seg2}
    addr_ctrl   = 2'd2   // reset request and test output control
  } reg_addr_t;

  // control register bits
  localparam int ctrl_rr_bit      = 0;  // reset request, holds the bit timing in init
  localparam int ctrl_tst_off_bit = 1;  // masks tst_clock and tst_sample

  // values after reset
  localparam int div_rst  = 1;
  localparam int sjw_rst  = 1;
  localparam int seg1_rst = 4;
  localparam int seg2_rst = 2;

  localparam logic ctrl_rr_rst      = 1'b1;  // come out of reset in init
  localparam logic ctrl_tst_off_rst = 1'b0;

endpackage

// ==== can_rx_sync.sv ====
module can_rx_sync (
  input  logic clk,
  input  logic reset_b,
  input  logic init,
  input  logic tq_tick,
  input  logic rxd,
  output logic rx_sync,
  output logic rx_fall
);

  logic rxd_s1;  // first stage, may go metastable
  logic rxd_s2;  // second stage

  // shift once per time quantum, recessive while in init
  always_ff @(posedge clk)
  begin
    if (!reset_b || init)
    begin
      rxd_s1 <= 1'b1;
      rxd_s2 <= 1'b1;
    end
    else if (tq_tick)
    begin
      rxd_s2 <= rxd_s1;
      rxd_s1 <= rxd;
    end
  end

  assign rx_sync = rxd_s2;

  // stage 2 still recessive, stage 1 already dominant, so stage 2 falls on the next tick.
  // holds for one quantum only, as that tick shifts the stages
  assign rx_fall = rxd_s2 & ~rxd_s1;

endmodule

// ==== can_timing_pkg.sv ====
package can_timing_pkg;

  // field widths of the bit timing word
  localparam int seg1_w = 4;  // tseg1 length minus one
  localparam int seg2_w = 3;  // tseg2 length minus one
  localparam int sjw_w  = 2;  // jump width minus one

  localparam int timing_w = sjw_w + seg1_w + seg2_w;  // {sjw, seg1, seg2}

  // prescaler divider, a tick every div_factor+1 clocks
  localparam int div_w = 8;

  // counts quanta within one segment, wide enough for a lengthened tseg1
  localparam int cnt_w = 5;

  // lsb of each field inside the timing word
  localparam int sjw_lsb  = 7;  // bits 8..7
  localparam int seg1_lsb = 3;  // bits 6..3
  localparam int seg2_lsb = 0;  // bits 2..0

  // one bit time is walked as sync, tseg1, tseg2
  typedef enum logic [1:0] {
    seg_sync,   // single quantum where edges are expected
    seg_tseg1,  // propagation and phase 1, sample point at its end
    seg_tseg2   // phase 2
  } seg_state_t;

endpackage

// ==== can_tq_prescaler.sv ====
module can_tq_prescaler #(
  parameter int div_w = can_timing_pkg::div_w
) (
  input  logic             clk,
  input  logic             reset_b,
  input  logic             init,
  input  logic [div_w-1:0] div_factor,
  output logic             tq_tick
);

  logic [div_w-1:0] count;  // quantum down-counter

  // one reload period is div_factor+1 clocks
  always_ff @(posedge clk)
  begin
    if (!reset_b)
      count <= '0;
    else if (init || count == '0)
      count <= div_factor;  // held at reload during init
    else
      count <= count - 1'b1;
  end

  // tick on the clock after the counter reaches zero
  always_ff @(posedge clk)
  begin
    if (!reset_b)
      tq_tick <= 1'b0;
    else
      tq_tick <= !init && count == '0;
  end

endmodule

// ==== tb_can_btl.sv ====
module tb_can_btl;

  localparam int div_w      = can_timing_pkg::div_w;
  localparam int adr_w      = can_reg_pkg::wb_adr_w;
  localparam int data_w     = can_reg_pkg::wb_dat_w;
  localparam int n_configs  = 8;
  localparam int n_bits     = 20;
  localparam int div_draw_w = 4;  // random dividers stay below 16
  // longest bit the random loop can draw, in clocks
  localparam int max_bit_clks = ((2 ** can_timing_pkg::seg1_w - 1) +
                                 (2 ** can_timing_pkg::seg2_w - 1) + 3) * (2 ** div_draw_w);
  localparam int cycle_limit  = n_configs * (n_bits + 2) * max_bit_clks + 20000;

  logic              clk, reset_b, cyc, stb, we;
  logic [adr_w-1:0]  adr;
  logic [data_w-1:0] dat_w, dat_r;
  logic              rxd, txd, busidle, interm3, transmit;
  logic              ack, sample, clock, rx_bit, tst_clock, tst_sample;

  int          errors, checks, cycles;
  int          exp_bit, exp_smp;  // current nominal bit and sample offset in clocks
  logic [31:0] lfsr_state;
  logic        check_nominal;     // checker compares bit timing while set
  logic        tst_off_exp;

  can_btl_top #(.div_w(div_w)) can_btl_top_i (.*);

  initial
  begin
    clk = 1'b0;
    forever #10 clk = ~clk;
  end

  initial
  begin
    cycles = 0;
    while (cycles < cycle_limit)
    begin
      @(posedge clk);
      cycles++;
    end
    $display("timeout: the tests did not finish within %0d clock cycles", cycle_limit);
    $display("RESULT: FAIL");
    $finish;
  end

  function automatic logic [31:0] lfsr_next(input logic [31:0] s);
    return {s[30:0], s[31] ^ s[21] ^ s[1] ^ s[0]};  // x^32 + x^22 + x^2 + x + 1
  endfunction

  function automatic int draw_bits(input int n);
    int v;
    v = 0;
    for (int i = 0; i < n; i++)
    begin
      lfsr_state = lfsr_next(lfsr_state);
      v = (v << 1) | int'(lfsr_state[0]);
    end
    return v;
  endfunction

  // sync + tseg1 + tseg2 quanta, sample at the end of tseg1
  function automatic void expected_bit_clocks(input int div, input int seg1, input int seg2,
                                              output int bit_clks, output int smp_clks);
    bit_clks = (1 + (seg1 + 1) + (seg2 + 1)) * (div + 1);
    smp_clks = (1 + (seg1 + 1)) * (div + 1);
  endfunction

  function automatic int timing_word(input int sjw, input int seg1, input int seg2);
    return (sjw << can_timing_pkg::sjw_lsb) | (seg1 << can_timing_pkg::seg1_lsb) |
           (seg2 << can_timing_pkg::seg2_lsb);
  endfunction

  task automatic log_error(input string text);
    $display("%s", text);
    errors++;
  endtask

  task automatic drive_slot();
    @(posedge clk);
    #2;
  endtask

  task automatic wb_cycle(input logic write, input int a, input int d, output int rd);
    int waited;
    drive_slot();
    cyc   = 1'b1;
    stb   = 1'b1;
    we    = write;
    adr   = adr_w'(a);
    dat_w = data_w'(d);
    waited = 0;
    @(negedge clk);
    while (!ack && waited < 8)
    begin
      @(negedge clk);
      waited++;
    end
    rd = int'(dat_r);
    if (!ack)
      log_error($sformatf("wishbone transfer to address %0d was never acknowledged", a));
    drive_slot();
    cyc = 1'b0;
    stb = 1'b0;
    we  = 1'b0;
  endtask

  task automatic wb_write(input int a, input int d);
    int rd_unused;
    wb_cycle(1'b1, a, d, rd_unused);
  endtask

  task automatic check_read(input int a, input int expected);
    int rd;
    wb_cycle(1'b0, a, 0, rd);
    checks++;
    if (rd != expected)
      log_error($sformatf("Error: dat_r at address %0d = 0x%0h, expected 0x%0h", a, rd, expected));
  endtask

  // hold init, load divider and timing, then release with the given tst_off
  task automatic configure(input int div, input int tword, input logic tst);
    wb_write(can_reg_pkg::addr_ctrl, 1 << can_reg_pkg::ctrl_rr_bit);
    wb_write(can_reg_pkg::addr_div, div);
    wb_write(can_reg_pkg::addr_timing, tword);
    wb_write(can_reg_pkg::addr_ctrl, int'(tst) << can_reg_pkg::ctrl_tst_off_bit);
    tst_off_exp = tst;
  endtask

  task automatic wait_for_pulse(input logic on_clock);
    @(negedge clk);
    while (!(on_clock ? clock : sample))
      @(negedge clk);
  endtask

  // bit spacing, sample offset and the test outputs, looked at on falling clock edges
  initial
  begin : compare_timing
    int since_clock;
    bit seen_clock;
    since_clock = 0;
    seen_clock  = 1'b0;
    forever
    begin
      @(negedge clk);
      since_clock++;
      if (!check_nominal)
        seen_clock = 1'b0;
      if (reset_b)
      begin
        if (!cyc && (tst_clock !== (clock & ~tst_off_exp) ||
                     tst_sample !== (sample & ~tst_off_exp)))
          log_error($sformatf("Error: tst_clock, tst_sample = 0x%0h, 0x%0h, expected 0x%0h, 0x%0h",
                              tst_clock, tst_sample, clock & ~tst_off_exp, sample & ~tst_off_exp));
        if (check_nominal && seen_clock && sample)
        begin
          checks++;
          if (since_clock != exp_smp)
            log_error($sformatf("Error: sample offset = 0x%0h clocks, expected 0x%0h",
                                since_clock, exp_smp));
          if (rx_bit !== 1'b1)
            log_error($sformatf("Error: rx_bit = 0x%0h, expected 0x1", rx_bit));
        end
        if (clock)
        begin
          checks++;
          if (check_nominal && seen_clock && since_clock != exp_bit)
            log_error($sformatf("Error: clock spacing = 0x%0h clocks, expected 0x%0h",
                                since_clock, exp_bit));
          seen_clock  = check_nominal;
          since_clock = 0;
        end
      end
    end
  end

  initial
  begin : run_tests
    int div, seg1, seg2, sjw, t0, len, tol, quiet;
    lfsr_state    = 32'h8521589b;
    errors        = 0;
    checks        = 0;
    check_nominal = 1'b0;
    tst_off_exp   = 1'b0;
    reset_b = 1'b0;
    cyc     = 1'b0;
    stb     = 1'b0;
    we      = 1'b0;
    adr     = '0;
    dat_w   = '0;
    rxd      = 1'b1;
    txd      = 1'b1;
    busidle  = 1'b0;
    interm3  = 1'b0;
    transmit = 1'b0;
    repeat (3) @(posedge clk);
    #2;
    reset_b = 1'b1;

    // reset request bit comes up set, nothing may move
    quiet = 0;
    repeat (200)
    begin
      @(negedge clk);
      if (clock || sample || tst_clock || tst_sample || !rx_bit)
        quiet++;
    end
    checks++;
    if (quiet != 0)
      log_error($sformatf("bit timing was active on %0d cycles during reset request", quiet));

    check_read(can_reg_pkg::addr_div, can_reg_pkg::div_rst);
    check_read(can_reg_pkg::addr_timing,
               timing_word(can_reg_pkg::sjw_rst, can_reg_pkg::seg1_rst, can_reg_pkg::seg2_rst));
    check_read(can_reg_pkg::addr_ctrl,
               (int'(can_reg_pkg::ctrl_rr_rst) << can_reg_pkg::ctrl_rr_bit) |
               (int'(can_reg_pkg::ctrl_tst_off_rst) << can_reg_pkg::ctrl_tst_off_bit));
    check_read(3, 0);
    wb_write(can_reg_pkg::addr_div, 'h5a);
    check_read(can_reg_pkg::addr_div, 'h5a);
    wb_write(can_reg_pkg::addr_timing, timing_word(2, 9, 5));
    check_read(can_reg_pkg::addr_timing, timing_word(2, 9, 5));
    wb_write(can_reg_pkg::addr_ctrl, 3);  // stays in init
    check_read(can_reg_pkg::addr_ctrl, 3);
    wb_write(3, 'hffff);
    // the hole write must leave every register alone
    check_read(can_reg_pkg::addr_div, 'h5a);
    check_read(can_reg_pkg::addr_timing, timing_word(2, 9, 5));
    check_read(can_reg_pkg::addr_ctrl, 3);

    // nominal bits with random settings, rxd recessive
    for (int n = 0; n < n_configs; n++)
    begin
      div  = draw_bits(div_draw_w);
      seg1 = draw_bits(can_timing_pkg::seg1_w);
      seg2 = draw_bits(can_timing_pkg::seg2_w);
      sjw  = draw_bits(can_timing_pkg::sjw_w);
      expected_bit_clocks(div, seg1, seg2, exp_bit, exp_smp);
      configure(div, timing_word(sjw, seg1, seg2), 1'b0);
      check_nominal = 1'b1;
      repeat (n_bits + 1) wait_for_pulse(1'b1);
      drive_slot();
      check_nominal = 1'b0;
    end

    // test outputs masked while the bit timing keeps running
    wb_write(can_reg_pkg::addr_ctrl, 1 << can_reg_pkg::ctrl_tst_off_bit);
    tst_off_exp = 1'b1;
    repeat (3) wait_for_pulse(1'b1);

    // hard sync on bus idle, edge early in the bit so a nominal bit would end too late
    div  = 1;
    seg1 = 4;
    seg2 = 2;
    sjw  = 1;
    configure(div, timing_word(sjw, seg1, seg2), 1'b0);
    busidle = 1'b1;
    wait_for_pulse(1'b1);
    drive_slot();
    rxd = 1'b0;
    t0  = cycles;
    wait_for_pulse(1'b1);
    len = cycles - t0;
    checks++;
    if (len > (3 + seg2 + 1) * (div + 1))
      log_error($sformatf("Error: clock came 0x%0h clocks after rxd fell, limit 0x%0h",
                          len, (3 + seg2 + 1) * (div + 1)));
    wait_for_pulse(1'b0);
    checks++;
    if (rx_bit !== 1'b0)
      log_error($sformatf("Error: rx_bit = 0x%0h, expected 0x0", rx_bit));
    drive_slot();
    rxd     = 1'b1;
    busidle = 1'b0;

    // resync, one edge late in tseg1 and one in tseg2
    div  = 3;
    seg1 = 6;
    seg2 = 6;
    sjw  = 2;
    tol  = (sjw + 1) * (div + 1);
    expected_bit_clocks(div, seg1, seg2, exp_bit, exp_smp);
    configure(div, timing_word(sjw, seg1, seg2), 1'b0);
    for (int p = 3; p <= seg1 + 4; p += seg1 + 1)
    begin
      wait_for_pulse(1'b1);
      t0 = cycles;
      repeat (p * (div + 1) - 1) @(posedge clk);
      drive_slot();
      rxd = 1'b0;
      wait_for_pulse(1'b1);
      len = cycles - t0;
      checks++;
      if (len < exp_bit - tol || len > exp_bit + tol)
        log_error($sformatf("Error: resync bit = 0x%0h clocks, expected 0x%0h to 0x%0h",
                            len, exp_bit - tol, exp_bit + tol));
      t0 = cycles;
      wait_for_pulse(1'b1);
      len = cycles - t0;
      checks++;
      if (len != exp_bit)
        log_error($sformatf("Error: clock spacing after resync = 0x%0h, expected 0x%0h",
                            len, exp_bit));
      drive_slot();
      rxd = 1'b1;
    end

    $display("checks: %0d, errors: %0d", checks, errors);
    if (errors == 0)
      $display("RESULT: PASS");
    else
      $display("RESULT: FAIL");
    $finish;
  end

endmodule

// ==== vlog.f ====
can_timing_pkg.sv
can_reg_pkg.sv
can_btl_regs.sv
can_tq_prescaler.sv
can_rx_sync.sv
can_bit_sequencer.sv
can_btl_top.sv
can_btl_properties.sv
tb_can_btl.sv
